/* rvDecPkg.sv */
package rvDecPkg;

  localparam int InstrWidth  = 32;
  localparam int RegIdxWidth = 5;

  // funct12 values of the SYSTEM encodings
  localparam logic [11:0] Funct12Ecall  = 12'h000;
  localparam logic [11:0] Funct12Ebreak = 12'h001;
  localparam logic [11:0] Funct12Mret   = 12'h302;
  localparam logic [11:0] Funct12Wfi    = 12'h105;

  // Major opcodes including the low two bits
  typedef enum logic [6:0] {
    OPC_OP       = 7'b0110011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_BRANCH   = 7'b1100011,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_MISC_MEM = 7'b0001111,
    OPC_SYSTEM   = 7'b1110011
  } opcodeT;

  typedef enum logic [2:0] {
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J,
    FMT_NONE
  } fmtT;

  typedef enum logic [5:0] {
    MN_ILLEGAL,
    MN_ADD, MN_SUB, MN_SLL, MN_SLT, MN_SLTU, MN_XOR, MN_SRL, MN_SRA, MN_OR, MN_AND,
    MN_ADDI, MN_SLTI, MN_SLTIU, MN_XORI, MN_ORI, MN_ANDI, MN_SLLI, MN_SRLI, MN_SRAI,
    MN_LB, MN_LH, MN_LW, MN_LBU, MN_LHU,
    MN_SB, MN_SH, MN_SW,
    MN_BEQ, MN_BNE, MN_BLT, MN_BGE, MN_BLTU, MN_BGEU,
    MN_JAL, MN_JALR, MN_LUI, MN_AUIPC,
    MN_ECALL, MN_EBREAK, MN_MRET, MN_WFI, MN_FENCE, MN_FENCE_I,
    MN_MUL, MN_MULH, MN_MULHSU, MN_MULHU, MN_DIV, MN_DIVU, MN_REM, MN_REMU
  } mnemT;

  // Stage 1 output
  typedef struct packed {
    opcodeT                 opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    // instr[31:20] for exact system matches
    logic [11:0]            funct12;
    // rs1 and rd bit fields both zero
    logic                   sysRegZero;
    fmtT                    fmt;
    logic [RegIdxWidth-1:0] rd;
    logic [RegIdxWidth-1:0] rs1;
    logic [RegIdxWidth-1:0] rs2;
    logic [InstrWidth-1:0]  imm;
  } fieldsT;

  // Final decode record
  typedef struct packed {
    mnemT                   mnem;
    fmtT                    fmt;
    logic [RegIdxWidth-1:0] rd;
    logic [RegIdxWidth-1:0] rs1;
    logic [RegIdxWidth-1:0] rs2;
    logic [InstrWidth-1:0]  imm;
  } decodedT;

  localparam decodedT IllegalRecord = '{
    mnem: MN_ILLEGAL,
    fmt:  FMT_NONE,
    rd:   '0,
    rs1:  '0,
    rs2:  '0,
    imm:  '0
  };

endpackage

/* rvFieldStage.sv */
`timescale 1ns/100ps

module rvFieldStage import rvDecPkg::*; (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  instrValid,
  input  logic [InstrWidth-1:0] instr,
  output logic                  fieldValid,
  output fieldsT                fields
);

  opcodeT                opcode;
  logic [2:0]            funct3;
  logic                  isShift;
  logic                  useRd;
  logic                  useRs1;
  logic                  useRs2;
  logic [InstrWidth-1:0] immI;
  logic [InstrWidth-1:0] immS;
  logic [InstrWidth-1:0] immB;
  logic [InstrWidth-1:0] immU;
  logic [InstrWidth-1:0] immJ;
  logic [InstrWidth-1:0] immShamt;
  fieldsT                nextFields;

  assign opcode = opcodeT'(instr[6:0]);
  assign funct3 = instr[14:12];

  // SLLI / SRLI / SRAI carry a shamt, not a signed immediate
  assign isShift = (opcode == OPC_OP_IMM) && (funct3 == 3'b001 || funct3 == 3'b101);

  assign immI     = {{20{instr[31]}}, instr[31:20]};
  assign immS     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign immB     = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immU     = {instr[31:12], 12'b0};
  assign immJ     = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign immShamt = {27'b0, instr[24:20]};

  always_comb begin
    nextFields.opcode     = opcode;
    nextFields.funct3     = funct3;
    nextFields.funct7     = instr[31:25];
    nextFields.funct12    = instr[31:20];
    nextFields.sysRegZero = (instr[19:15] == '0) && (instr[11:7] == '0);
    nextFields.fmt        = FMT_NONE;
    nextFields.imm        = '0;
    useRd                 = 1'b0;
    useRs1                = 1'b0;
    useRs2                = 1'b0;

    case (opcode)
      OPC_OP: begin
        nextFields.fmt = FMT_R;
        useRd          = 1'b1;
        useRs1         = 1'b1;
        useRs2         = 1'b1;
      end
      OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
        nextFields.fmt = FMT_I;
        nextFields.imm = isShift ? immShamt : immI;
        useRd          = 1'b1;
        useRs1         = 1'b1;
      end
      OPC_STORE: begin
        nextFields.fmt = FMT_S;
        nextFields.imm = immS;
        useRs1         = 1'b1;
        useRs2         = 1'b1;
      end
      OPC_BRANCH: begin
        nextFields.fmt = FMT_B;
        nextFields.imm = immB;
        useRs1         = 1'b1;
        useRs2         = 1'b1;
      end
      OPC_LUI, OPC_AUIPC: begin
        nextFields.fmt = FMT_U;
        nextFields.imm = immU;
        useRd          = 1'b1;
      end
      OPC_JAL: begin
        nextFields.fmt = FMT_J;
        nextFields.imm = immJ;
        useRd          = 1'b1;
      end
      // MISC-MEM, SYSTEM and unknown opcodes keep no operands
      default: begin
        nextFields.fmt = FMT_NONE;
      end
    endcase

    nextFields.rd  = useRd  ? instr[11:7]  : '0;
    nextFields.rs1 = useRs1 ? instr[19:15] : '0;
    nextFields.rs2 = useRs2 ? instr[24:20] : '0;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      fieldValid <= 1'b0;
    end else begin
      fieldValid <= instrValid;
    end
  end

  always_ff @(posedge clk) begin
    fields <= nextFields;
  end

endmodule

/* rvMatchStage.sv */
`timescale 1ns/100ps

module rvMatchStage import rvDecPkg::*; #(
  parameter bit MulDivEnable = 1'b1
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    fieldValid,
  input  fieldsT  fields,
  output logic    decValid,
  output decodedT dec
);

  mnemT    mnem;
  decodedT nextDec;

  always_comb begin
    mnem = MN_ILLEGAL;
    case (fields.opcode)
      OPC_OP: begin
        if (fields.funct7 == 7'b0000000) begin
          case (fields.funct3)
            3'b000:  mnem = MN_ADD;
            3'b001:  mnem = MN_SLL;
            3'b010:  mnem = MN_SLT;
            3'b011:  mnem = MN_SLTU;
            3'b100:  mnem = MN_XOR;
            3'b101:  mnem = MN_SRL;
            3'b110:  mnem = MN_OR;
            default: mnem = MN_AND;
          endcase
        end else if (fields.funct7 == 7'b0100000) begin
          if (fields.funct3 == 3'b000) begin
            mnem = MN_SUB;
          end else if (fields.funct3 == 3'b101) begin
            mnem = MN_SRA;
          end
        end else if (fields.funct7 == 7'b0000001 && MulDivEnable) begin
          // M extension
          case (fields.funct3)
            3'b000:  mnem = MN_MUL;
            3'b001:  mnem = MN_MULH;
            3'b010:  mnem = MN_MULHSU;
            3'b011:  mnem = MN_MULHU;
            3'b100:  mnem = MN_DIV;
            3'b101:  mnem = MN_DIVU;
            3'b110:  mnem = MN_REM;
            default: mnem = MN_REMU;
          endcase
        end
      end
      OPC_OP_IMM: begin
        case (fields.funct3)
          3'b000: mnem = MN_ADDI;
          3'b010: mnem = MN_SLTI;
          3'b011: mnem = MN_SLTIU;
          3'b100: mnem = MN_XORI;
          3'b110: mnem = MN_ORI;
          3'b111: mnem = MN_ANDI;
          3'b001: mnem = (fields.funct7 == 7'b0000000) ? MN_SLLI : MN_ILLEGAL;
          default: begin
            if (fields.funct7 == 7'b0000000) begin
              mnem = MN_SRLI;
            end else if (fields.funct7 == 7'b0100000) begin
              mnem = MN_SRAI;
            end
          end
        endcase
      end
      OPC_LOAD: begin
        case (fields.funct3)
          3'b000:  mnem = MN_LB;
          3'b001:  mnem = MN_LH;
          3'b010:  mnem = MN_LW;
          3'b100:  mnem = MN_LBU;
          3'b101:  mnem = MN_LHU;
          default: mnem = MN_ILLEGAL;
        endcase
      end
      OPC_STORE: begin
        case (fields.funct3)
          3'b000:  mnem = MN_SB;
          3'b001:  mnem = MN_SH;
          3'b010:  mnem = MN_SW;
          default: mnem = MN_ILLEGAL;
        endcase
      end
      OPC_BRANCH: begin
        case (fields.funct3)
          3'b000:  mnem = MN_BEQ;
          3'b001:  mnem = MN_BNE;
          3'b100:  mnem = MN_BLT;
          3'b101:  mnem = MN_BGE;
          3'b110:  mnem = MN_BLTU;
          3'b111:  mnem = MN_BGEU;
          default: mnem = MN_ILLEGAL;
        endcase
      end
      OPC_JAL:   mnem = MN_JAL;
      OPC_JALR:  mnem = (fields.funct3 == 3'b000) ? MN_JALR : MN_ILLEGAL;
      OPC_LUI:   mnem = MN_LUI;
      OPC_AUIPC: mnem = MN_AUIPC;
      OPC_MISC_MEM: begin
        // Any FENCE with funct3 000 is accepted, FENCE.I only as 0000100F
        if (fields.funct3 == 3'b000) begin
          mnem = MN_FENCE;
        end else if (fields.funct3 == 3'b001 && fields.sysRegZero && fields.funct12 == '0) begin
          mnem = MN_FENCE_I;
        end
      end
      OPC_SYSTEM: begin
        if (fields.funct3 == 3'b000 && fields.sysRegZero) begin
          case (fields.funct12)
            Funct12Ecall:  mnem = MN_ECALL;
            Funct12Ebreak: mnem = MN_EBREAK;
            Funct12Mret:   mnem = MN_MRET;
            Funct12Wfi:    mnem = MN_WFI;
            default:       mnem = MN_ILLEGAL;
          endcase
        end
      end
      default: mnem = MN_ILLEGAL;
    endcase
  end

  always_comb begin
    if (mnem == MN_ILLEGAL) begin
      nextDec = IllegalRecord;
    end else begin
      nextDec.mnem = mnem;
      nextDec.fmt  = fields.fmt;
      nextDec.rd   = fields.rd;
      nextDec.rs1  = fields.rs1;
      nextDec.rs2  = fields.rs2;
      nextDec.imm  = fields.imm;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      decValid <= 1'b0;
    end else begin
      decValid <= fieldValid;
    end
  end

  always_ff @(posedge clk) begin
    dec <= nextDec;
  end

endmodule

/* rvDecTop.sv */
`timescale 1ns/100ps

module rvDecTop import rvDecPkg::*; #(
  parameter bit MulDivEnable = 1'b1
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  instrValid,
  input  logic [InstrWidth-1:0] instr,
  output logic                  decValid,
  output decodedT               dec
);

  logic   fieldValid;
  fieldsT fields;

  // Opcode class, immediate and register fields
  rvFieldStage fieldStage0 (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .fieldValid (fieldValid),
    .fields     (fields)
  );

  // funct3/funct7 and system word matching
  rvMatchStage #(
    .MulDivEnable (MulDivEnable)
  ) matchStage0 (
    .clk        (clk),
    .rstN       (rstN),
    .fieldValid (fieldValid),
    .fields     (fields),
    .decValid   (decValid),
    .dec        (dec)
  );

endmodule

/* rvDec_assert.sv */
`timescale 1ns/100ps

module rvDecAssert import rvDecPkg::*; #(
  parameter bit MulDivEnable = 1'b1
) (
  input logic                  clk,
  input logic                  rstN,
  input logic                  instrValid,
  input logic [InstrWidth-1:0] instr,
  input logic                  decValid,
  input decodedT               dec
);

  // Mnemonics indexed by funct3
  localparam mnemT RegOps [0:7] = '{MN_ADD, MN_SLL, MN_SLT, MN_SLTU,
                                    MN_XOR, MN_SRL, MN_OR, MN_AND};
  localparam mnemT MulOps [0:7] = '{MN_MUL, MN_MULH, MN_MULHSU, MN_MULHU,
                                    MN_DIV, MN_DIVU, MN_REM, MN_REMU};
  localparam mnemT ImmOps [0:7] = '{MN_ADDI, MN_SLLI, MN_SLTI, MN_SLTIU,
                                    MN_XORI, MN_SRLI, MN_ORI, MN_ANDI};
  localparam mnemT LoadOps [0:7] = '{MN_LB, MN_LH, MN_LW, MN_ILLEGAL,
                                     MN_LBU, MN_LHU, MN_ILLEGAL, MN_ILLEGAL};
  localparam mnemT StoreOps [0:7] = '{MN_SB, MN_SH, MN_SW, MN_ILLEGAL,
                                      MN_ILLEGAL, MN_ILLEGAL, MN_ILLEGAL, MN_ILLEGAL};
  localparam mnemT BranchOps [0:7] = '{MN_BEQ, MN_BNE, MN_ILLEGAL, MN_ILLEGAL,
                                       MN_BLT, MN_BGE, MN_BLTU, MN_BGEU};

  logic [InstrWidth-1:0] instrD1;
  logic [InstrWidth-1:0] instrD2;
  decodedT               expDec;
  int                    errCount = 0;

  function automatic decodedT refDecode(input logic [31:0] w);
    decodedT    d;
    logic [2:0] f3;
    logic [6:0] f7;
    f3     = w[14:12];
    f7     = w[31:25];
    d      = '0;
    d.fmt  = FMT_NONE;
    d.mnem = MN_ILLEGAL;
    case (w[6:0])
      7'b0110011: begin
        d.fmt = FMT_R;
        if (f7 == 7'b0000000) begin
          d.mnem = RegOps[f3];
        end else if (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)) begin
          d.mnem = (f3 == 3'b000) ? MN_SUB : MN_SRA;
        end else if (f7 == 7'b0000001 && MulDivEnable) begin
          d.mnem = MulOps[f3];
        end
      end
      7'b0010011: begin
        d.fmt  = FMT_I;
        d.imm  = {{20{w[31]}}, w[31:20]};
        d.mnem = ImmOps[f3];
        if (f3 == 3'b001 || f3 == 3'b101) begin
          d.imm = {27'b0, w[24:20]};
          if (f3 == 3'b101 && f7 == 7'b0100000) begin
            d.mnem = MN_SRAI;
          end else if (f7 != 7'b0000000) begin
            d.mnem = MN_ILLEGAL;
          end
        end
      end
      // LOAD and JALR share the I immediate
      7'b0000011, 7'b1100111: begin
        d.fmt  = FMT_I;
        d.imm  = {{20{w[31]}}, w[31:20]};
        d.mnem = w[6] ? ((f3 == 3'b000) ? MN_JALR : MN_ILLEGAL) : LoadOps[f3];
      end
      7'b0100011: begin
        d.fmt  = FMT_S;
        d.imm  = {{20{w[31]}}, w[31:25], w[11:7]};
        d.mnem = StoreOps[f3];
      end
      7'b1100011: begin
        d.fmt  = FMT_B;
        d.imm  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        d.mnem = BranchOps[f3];
      end
      7'b0110111, 7'b0010111: begin
        d.fmt  = FMT_U;
        d.imm  = {w[31:12], 12'b0};
        d.mnem = w[5] ? MN_LUI : MN_AUIPC;
      end
      7'b1101111: begin
        d.fmt  = FMT_J;
        d.imm  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        d.mnem = MN_JAL;
      end
      7'b0001111: begin
        if (f3 == 3'b000) begin
          d.mnem = MN_FENCE;
        end else if (w == 32'h0000100F) begin
          d.mnem = MN_FENCE_I;
        end
      end
      7'b1110011: begin
        case (w)
          32'h00000073: d.mnem = MN_ECALL;
          32'h00100073: d.mnem = MN_EBREAK;
          32'h30200073: d.mnem = MN_MRET;
          32'h10500073: d.mnem = MN_WFI;
          default:      d.mnem = MN_ILLEGAL;
        endcase
      end
      default: d.mnem = MN_ILLEGAL;
    endcase
    if (d.mnem == MN_ILLEGAL) begin
      d.fmt = FMT_NONE;
      d.imm = '0;
    end else begin
      if (d.fmt inside {FMT_R, FMT_I, FMT_U, FMT_J})
        d.rd = w[11:7];
      if (d.fmt inside {FMT_R, FMT_I, FMT_S, FMT_B})
        d.rs1 = w[19:15];
      if (d.fmt inside {FMT_R, FMT_S, FMT_B})
        d.rs2 = w[24:20];
    end
    return d;
  endfunction

  // Instruction word from two edges back
  always_ff @(posedge clk) begin
    instrD1 <= instr;
    instrD2 <= instrD1;
  end

  assign expDec = refDecode(instrD2);

  validLatency: assert property (@(posedge clk)
    decValid == (rstN && $past(rstN, 1) && $past(rstN, 2) && $past(instrValid, 2)))
  else begin
    $error("FAILED decValid: expected %h, got %h", !$sampled(decValid), $sampled(decValid));
    errCount++;
  end

  mnemMatch: assert property (@(posedge clk) disable iff (!rstN)
    decValid |-> dec.mnem == expDec.mnem)
  else begin
    $error("FAILED dec.mnem: expected %h, got %h",
           $sampled(expDec.mnem), $sampled(dec.mnem));
    errCount++;
  end

  recordMatch: assert property (@(posedge clk) disable iff (!rstN)
    decValid |-> dec == expDec)
  else begin
    $error("FAILED dec: expected %h, got %h", $sampled(expDec), $sampled(dec));
    errCount++;
  end

endmodule

bind rvDecTop rvDecAssert #(
  .MulDivEnable (MulDivEnable)
) decCheck0 (
  .clk        (clk),
  .rstN       (rstN),
  .instrValid (instrValid),
  .instr      (instr),
  .decValid   (decValid),
  .dec        (dec)
);

/* tbRvDec.sv */
`timescale 1ns/100ps

module tbRvDec import rvDecPkg::*; ();

  localparam int NumCycles   = 3000;
  localparam int ResetCycles = 8;
  localparam int CycleLimit  = NumCycles + 50;
  localparam int DriveDelay  = 2;

  localparam logic [6:0] KnownOpcodes [0:10] = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h63, 7'h6f,
                                                  7'h67, 7'h37, 7'h17, 7'h0f, 7'h73};
  // Exact system words, then near misses
  localparam logic [31:0] SystemWords [0:11] = '{
    32'h00000073, 32'h00100073, 32'h30200073, 32'h10500073, 32'h0000100F, 32'h0FF0000F,
    32'h00000173, 32'h00200073, 32'h0000200F, 32'h0000108F, 32'h30200072, 32'h10500873
  };
  localparam logic [6:0] Funct7Picks [0:2] = '{7'b0000000, 7'b0100000, 7'b0000001};

  logic                  clk;
  logic                  rstN;
  logic                  instrValid;
  logic [InstrWidth-1:0] instr;
  logic                  decValid;
  decodedT               dec;

  logic [31:0] lcgState;
  int          cycleCount = 0;
  int          sentCount = 0;
  int          seenCount = 0;

  rvDecTop #(
    .MulDivEnable (1'b1)
  ) dut0 (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .decValid   (decValid),
    .dec        (dec)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic logic [31:0] pickInstr();
    logic [31:0] r;
    logic [31:0] sel;
    logic [3:0]  opIdx;
    logic [3:0]  sysIdx;
    r      = nextRandom();
    sel    = nextRandom();
    opIdx  = 4'(sel[29:16] % 11);
    sysIdx = 4'(sel[29:16] % 12);
    if (sel[31:30] == 2'b11) begin
      return sel[25] ? r : SystemWords[sysIdx];
    end
    r[6:0] = KnownOpcodes[opIdx];
    // Steer OP and OP-IMM towards base, alternate and M funct7
    if ((r[6:0] == 7'h33 || r[6:0] == 7'h13) && sel[27:26] != 2'b11) begin
      r[31:25] = Funct7Picks[sel[27:26]];
    end
    return r;
  endfunction

  always @(posedge clk) begin
    if (rstN && decValid) begin
      seenCount <= seenCount + 1;
    end
  end

  always @(posedge clk) begin
    if (rstN) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= CycleLimit) begin
        $display("Timeout after %0d cycles, %0d items sent, %0d decoded, %0d errors",
                 cycleCount, sentCount, seenCount, dut0.decCheck0.errCount);
        $display("Finished with errors");
        $finish;
      end
    end
  end

  initial begin
    logic [31:0] strobe;
    int          errors;
    clk        = 1'b0;
    rstN       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    lcgState   = 32'hbac1_6fc0;
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay rstN = 1'b1;

    repeat (NumCycles) begin
      @(posedge clk);
      #DriveDelay;
      strobe     = nextRandom();
      instrValid = strobe[31:30] != 2'b00;
      instr      = pickInstr();
      if (instrValid) begin
        sentCount++;
      end
    end
    @(posedge clk);
    #DriveDelay instrValid = 1'b0;

    wait (seenCount == sentCount);
    repeat (2) @(posedge clk);
    errors = dut0.decCheck0.errCount;
    $display("Items sent %0d, decoded %0d, errors %0d", sentCount, seenCount, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* compile.f */
rvDecPkg.sv
rvFieldStage.sv
rvMatchStage.sv
rvDecTop.sv
rvDec_assert.sv
tbRvDec.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tbRvDec -f compile.f -o simRvDec

./obj_dir/simRvDec +verilator+error+limit+100000 | tee sim.log

if grep -q "^Finished with no errors$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
